// File: common/hci_csr_pkg.sv
/* APB request and response types, PIO register map and
   register field positions */
`default_nettype none

package hci_csr_pkg;

  localparam int ApbAddrWidth = 8;
  localparam int DataWidth    = 32;

  // Byte offsets of the PIO registers
  typedef enum logic [ApbAddrWidth-1:0] {
    RESET_CONTROL         = 8'h00,
    QUEUE_THLD_CTRL       = 8'h04,
    DATA_BUFFER_THLD_CTRL = 8'h08,
    COMMAND_PORT          = 8'h0C,
    XFER_DATA_PORT        = 8'h10,
    RESPONSE_PORT         = 8'h14,
    QUEUE_STATUS          = 8'h18
  } hci_reg_e;

  typedef struct packed {
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [ApbAddrWidth-1:0] paddr;
    logic [DataWidth-1:0]    pwdata;
  } apb_req_t;

  typedef struct packed {
    logic                 pready;
    logic [DataWidth-1:0] prdata;
    logic                 pslverr;
  } apb_rsp_t;

  // RESET_CONTROL bits, also the empty flags in QUEUE_STATUS
  localparam int RstCmdBit  = 0;
  localparam int RstRxBit   = 1;
  localparam int RstTxBit   = 2;
  localparam int RstRespBit = 3;

  // QUEUE_THLD_CTRL fields
  localparam int CmdThldLsb  = 0;
  localparam int CmdThldMsb  = 7;
  localparam int RespThldLsb = 8;
  localparam int RespThldMsb = 15;

  // DATA_BUFFER_THLD_CTRL fields, log2 encoded
  localparam int TxThldLsb = 0;
  localparam int TxThldMsb = 2;
  localparam int RxThldLsb = 8;
  localparam int RxThldMsb = 10;

endpackage

`default_nettype wire

// File: common/hci_queue_pkg.sv
/* Queue depths and widths, command and threshold structs,
   clamp limits and command assembler states */
`default_nettype none

package hci_queue_pkg;

  localparam int CmdDepth  = 8;
  localparam int TxDepth   = 16;
  localparam int RxDepth   = 16;
  localparam int RespDepth = 8;

  localparam int XferWidth = 32;            // One dword
  localparam int CmdWidth  = 2 * XferWidth; // Two dwords per command
  localparam int RespWidth = 32;
  localparam int ThldWidth = 8;

  localparam int CmdCntWidth  = $clog2(CmdDepth + 1);
  localparam int TxCntWidth   = $clog2(TxDepth + 1);
  localparam int RxCntWidth   = $clog2(RxDepth + 1);
  localparam int RespCntWidth = $clog2(RespDepth + 1);

  // Clamp limits for the threshold fields
  localparam int CmdThldMax  = CmdDepth;
  localparam int RespThldMax = RespDepth - 1;
  localparam int TxThldClamp = $clog2(TxDepth) - 1;
  localparam int RxThldClamp = $clog2(RxDepth) - 2;

  typedef struct packed {
    logic [XferWidth-1:0] dword_hi;
    logic [XferWidth-1:0] dword_lo;
  } hci_cmd_t;

  typedef struct packed {
    logic [ThldWidth-1:0] cmd;
    logic [ThldWidth-1:0] resp;
    logic [ThldWidth-1:0] tx;
    logic [ThldWidth-1:0] rx;
  } hci_thld_t;

  typedef struct packed {
    logic cmd;
    logic rx;
    logic tx;
    logic resp;
  } hci_qrst_t;

  typedef enum logic [1:0] {
    WAIT_LO,
    WAIT_HI,
    PUSH
  } asm_state_e;

endpackage

`default_nettype wire

// File: queues/hci_fifo.sv
/* Synchronous valid/ready FIFO with flush and fill count */
`timescale 1ns/1ps
`default_nettype none

module hci_fifo #(
  parameter int Width = 32,
  parameter int Depth = 8
) (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire logic                       flush_i,
  input  wire logic                       wvalid_i,
  input  wire logic [Width-1:0]           wdata_i,
  output logic                            wready_o,
  output logic                            rvalid_o,
  output logic [Width-1:0]                rdata_o,
  input  wire logic                       rready_i,
  output logic [$clog2(Depth+1)-1:0]      count_o
);

  localparam int PtrWidth = $clog2(Depth);
  localparam int CntWidth = $clog2(Depth + 1);

  logic [Width-1:0]    mem_q [Depth];
  logic [PtrWidth-1:0] wptr_q, rptr_q;
  logic [CntWidth-1:0] cnt_q, cnt_d;
  logic                wready_q;
  logic                push, pop;

  assign push     = wvalid_i && wready_q;
  assign pop      = rvalid_o && rready_i;
  assign rvalid_o = cnt_q != '0;
  assign rdata_o  = mem_q[rptr_q];
  assign wready_o = wready_q;
  assign count_o  = cnt_q;

  always_comb begin
    if (flush_i) cnt_d = '0;  // Flush wins over push and pop
    else         cnt_d = cnt_q + CntWidth'(push) - CntWidth'(pop);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q   <= '0;
      rptr_q   <= '0;
      cnt_q    <= '0;
      wready_q <= 1'b0;
    end else begin
      cnt_q    <= cnt_d;
      wready_q <= cnt_d != CntWidth'(Depth);  // Registered, low while in reset
      if (flush_i) begin
        wptr_q <= '0;
        rptr_q <= '0;
      end else begin
        if (push) wptr_q <= (wptr_q == PtrWidth'(Depth - 1)) ? '0 : wptr_q + 1'b1;
        if (pop)  rptr_q <= (rptr_q == PtrWidth'(Depth - 1)) ? '0 : rptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push && !flush_i) mem_q[wptr_q] <= wdata_i;
  end

  // A full FIFO has its write pointer on the read head and takes no write
  a_no_write_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cnt_q == CntWidth'(Depth)) |-> (wptr_q == rptr_q) && !push);

endmodule

`default_nettype wire

// File: source/hci_csr_decode.sv
/* APB slave for the PIO registers: register storage, port steering,
   wait states and the read data path */
`timescale 1ns/1ps
`default_nettype none

module hci_csr_decode
  import hci_csr_pkg::*;
  import hci_queue_pkg::*;
(
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,
  input  wire apb_req_t                    apb_i,
  output apb_rsp_t                         apb_o,
  output logic                             cmd_dw_valid_o,
  output logic [DataWidth-1:0]             cmd_dw_o,
  input  wire logic                        cmd_dw_ready_i,
  output logic                             tx_push_o,
  output logic [DataWidth-1:0]             tx_data_o,
  input  wire logic                        tx_full_i,
  output logic                             rx_pop_o,
  input  wire logic [DataWidth-1:0]        rx_head_i,
  input  wire logic                        rx_empty_i,
  output logic                             resp_pop_o,
  input  wire logic [DataWidth-1:0]        resp_head_i,
  input  wire logic                        resp_empty_i,
  output hci_qrst_t                        qrst_req_o,
  input  wire hci_qrst_t                   qrst_clr_i,
  output logic [1:0][DataWidth-1:0]        thld_raw_o,
  input  wire logic [DataWidth-1:0]        status_i
);

  hci_reg_e                  reg_addr;
  hci_qrst_t                 rst_q, rst_set;
  logic [1:0][DataWidth-1:0] thld_q;  // [0] QUEUE_THLD_CTRL, [1] DATA_BUFFER_THLD_CTRL
  logic                      access, wr_acc;
  logic                      ready, err;
  logic [DataWidth-1:0]      rdata;

  assign reg_addr = hci_reg_e'(apb_i.paddr);
  assign access   = apb_i.psel && apb_i.penable;
  assign wr_acc   = access && apb_i.pwrite;

  // Writing a one starts the flush of that queue
  always_comb begin
    rst_set = '0;
    if (wr_acc && reg_addr == RESET_CONTROL) begin
      rst_set.cmd  = apb_i.pwdata[RstCmdBit];
      rst_set.rx   = apb_i.pwdata[RstRxBit];
      rst_set.tx   = apb_i.pwdata[RstTxBit];
      rst_set.resp = apb_i.pwdata[RstRespBit];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_q  <= '0;
      thld_q <= '0;
    end else begin
      rst_q <= (rst_q & ~qrst_clr_i) | rst_set;  // A new set beats the clear
      if (wr_acc && reg_addr == QUEUE_THLD_CTRL)       thld_q[0] <= apb_i.pwdata;
      if (wr_acc && reg_addr == DATA_BUFFER_THLD_CTRL) thld_q[1] <= apb_i.pwdata;
    end
  end

  // Port steering, wait states and read mux
  always_comb begin
    ready          = 1'b1;
    err            = 1'b0;
    rdata          = '0;
    cmd_dw_valid_o = 1'b0;
    tx_push_o      = 1'b0;
    rx_pop_o       = 1'b0;
    resp_pop_o     = 1'b0;
    case (reg_addr)
      RESET_CONTROL: begin
        rdata[RstCmdBit]  = rst_q.cmd;
        rdata[RstRxBit]   = rst_q.rx;
        rdata[RstTxBit]   = rst_q.tx;
        rdata[RstRespBit] = rst_q.resp;
      end
      QUEUE_THLD_CTRL:       rdata = thld_q[0];
      DATA_BUFFER_THLD_CTRL: rdata = thld_q[1];
      COMMAND_PORT: begin
        if (apb_i.pwrite && !rst_q.cmd) begin
          cmd_dw_valid_o = access;
          ready          = cmd_dw_ready_i;  // Stall while the assembler is busy
        end
      end
      XFER_DATA_PORT: begin
        if (apb_i.pwrite) begin
          if (!rst_q.tx) begin
            tx_push_o = access && !tx_full_i;
            ready     = !tx_full_i;
          end
        end else if (!rst_q.rx) begin
          err      = rx_empty_i;
          rx_pop_o = access && !rx_empty_i;
          rdata    = rx_head_i;
        end
      end
      RESPONSE_PORT: begin
        if (!apb_i.pwrite && !rst_q.resp) begin
          err        = resp_empty_i;
          resp_pop_o = access && !resp_empty_i;
          rdata      = resp_head_i;
        end
      end
      QUEUE_STATUS: rdata = status_i;
      default:      err = 1'b1;  // Unmapped offset
    endcase
  end

  assign cmd_dw_o      = apb_i.pwdata;
  assign tx_data_o     = apb_i.pwdata;
  assign qrst_req_o    = rst_q;
  assign thld_raw_o    = thld_q;
  assign apb_o.pready  = access && ready;
  assign apb_o.pslverr = access && err;
  assign apb_o.prdata  = rdata;

  // An error only ends a transfer, it never shows during a wait state
  a_err_needs_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    apb_o.pslverr |-> apb_o.pready && access);

endmodule

`default_nettype wire

// File: source/hci_cmd_assembler.sv
/* Command assembler, packs two port dwords into one 64-bit command */
`timescale 1ns/1ps
`default_nettype none

module hci_cmd_assembler
  import hci_queue_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 dw_valid_i,
  input  wire logic [XferWidth-1:0] dw_i,
  output logic                      dw_ready_o,
  input  wire logic                 flush_i,
  output logic                      cmd_valid_o,
  output hci_cmd_t                  cmd_o,
  input  wire logic                 cmd_ready_i
);

  asm_state_e state_q;
  hci_cmd_t   cmd_q;

  assign dw_ready_o  = state_q != PUSH;  // No dwords taken while a command waits
  assign cmd_valid_o = state_q == PUSH;
  assign cmd_o       = cmd_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= WAIT_LO;
    end else if (flush_i) begin
      state_q <= WAIT_LO;  // Drop a half-built command
    end else begin
      case (state_q)
        WAIT_LO: if (dw_valid_i) state_q <= WAIT_HI;
        WAIT_HI: if (dw_valid_i) state_q <= PUSH;
        PUSH:    if (cmd_ready_i) state_q <= WAIT_LO;
        default: state_q <= WAIT_LO;
      endcase
    end
  end

  // First dword is the low half
  always_ff @(posedge clk_i) begin
    if (dw_valid_i && state_q == WAIT_LO) cmd_q.dword_lo <= dw_i;
    if (dw_valid_i && state_q == WAIT_HI) cmd_q.dword_hi <= dw_i;
  end

  a_cmd_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_o && !cmd_ready_i && !flush_i |=> cmd_valid_o && $stable(cmd_o));

endmodule

`default_nettype wire

// File: source/hci_queue_ctrl.sv
/* Queue controller: threshold clamping, self-clearing queue resets
   and the QUEUE_STATUS flags */
`timescale 1ns/1ps
`default_nettype none

module hci_queue_ctrl
  import hci_csr_pkg::*;
  import hci_queue_pkg::*;
(
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic [1:0][DataWidth-1:0] thld_raw_i,
  input  wire hci_qrst_t                 qrst_req_i,
  input  wire logic                      cmd_empty_i,
  input  wire logic                      rx_empty_i,
  input  wire logic                      tx_empty_i,
  input  wire logic                      resp_empty_i,
  input  wire logic [CmdCntWidth-1:0]    cmd_cnt_i,
  input  wire logic [RxCntWidth-1:0]     rx_cnt_i,
  input  wire logic [TxCntWidth-1:0]     tx_cnt_i,
  input  wire logic [RespCntWidth-1:0]   resp_cnt_i,
  output hci_thld_t                      thld_o,
  output hci_qrst_t                      flush_o,
  output hci_qrst_t                      qrst_clr_o,
  output logic [DataWidth-1:0]           status_o
);

  logic [CmdThldMsb-CmdThldLsb:0]   cmd_raw;
  logic [RespThldMsb-RespThldLsb:0] resp_raw;
  logic [TxThldMsb-TxThldLsb:0]     tx_raw;
  logic [RxThldMsb-RxThldLsb:0]     rx_raw;
  hci_qrst_t                        empty, clr_q;
  logic                             cmd_room, resp_above, tx_room, rx_above;

  assign cmd_raw  = thld_raw_i[0][CmdThldMsb:CmdThldLsb];
  assign resp_raw = thld_raw_i[0][RespThldMsb:RespThldLsb];
  assign tx_raw   = thld_raw_i[1][TxThldMsb:TxThldLsb];
  assign rx_raw   = thld_raw_i[1][RxThldMsb:RxThldLsb];

  assign empty = '{cmd: cmd_empty_i, rx: rx_empty_i, tx: tx_empty_i, resp: resp_empty_i};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      thld_o <= '0;
      clr_q  <= '0;
    end else begin
      thld_o.cmd  <= (cmd_raw > CmdThldMax) ? ThldWidth'(CmdThldMax) : cmd_raw;
      thld_o.resp <= (resp_raw > RespThldMax) ? ThldWidth'(RespThldMax) : resp_raw;
      // TX and RX fields encode 2^(field+1) entries
      thld_o.tx <= ((1 << (tx_raw + 1)) > TxDepth) ? ThldWidth'(TxThldClamp)
                                                    : ThldWidth'(tx_raw);
      thld_o.rx <= ((1 << (rx_raw + 1)) >= RxDepth) ? ThldWidth'(RxThldClamp)
                                                     : ThldWidth'(rx_raw);
      clr_q <= qrst_req_i & empty & ~clr_q;  // One pulse per drained queue
    end
  end

  assign flush_o    = qrst_req_i;
  assign qrst_clr_o = clr_q;

  assign cmd_room   = (CmdDepth - int'(cmd_cnt_i)) >= int'(thld_o.cmd);
  assign resp_above = int'(resp_cnt_i) > int'(thld_o.resp);
  assign tx_room    = (TxDepth - int'(tx_cnt_i)) >= (1 << (thld_o.tx + 1));
  assign rx_above   = int'(rx_cnt_i) >= (1 << (thld_o.rx + 1));

  always_comb begin
    status_o             = '0;
    status_o[RstCmdBit]  = cmd_empty_i;
    status_o[RstRxBit]   = rx_empty_i;
    status_o[RstTxBit]   = tx_empty_i;
    status_o[RstRespBit] = resp_empty_i;
    status_o[4]          = cmd_room;
    status_o[5]          = resp_above;
    status_o[6]          = tx_room;
    status_o[7]          = rx_above;
    status_o[15:8]       = thld_o.cmd;  // Clamped value for software
  end

endmodule

`default_nettype wire

// File: source/hci_pio_top.sv
/* PIO queue block top: CSR decoder, command assembler, queue
   controller and the four queues */
`timescale 1ns/1ps
`default_nettype none

module hci_pio_top
  import hci_csr_pkg::*;
  import hci_queue_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire apb_req_t             apb_i,
  output apb_rsp_t                  apb_o,
  output logic                      cmd_valid_o,
  output hci_cmd_t                  cmd_o,
  input  wire logic                 cmd_ready_i,
  output logic                      tx_valid_o,
  output logic [XferWidth-1:0]      tx_data_o,
  input  wire logic                 tx_ready_i,
  input  wire logic                 rx_valid_i,
  input  wire logic [XferWidth-1:0] rx_data_i,
  output logic                      rx_ready_o,
  input  wire logic                 resp_valid_i,
  input  wire logic [RespWidth-1:0] resp_data_i,
  output logic                      resp_ready_o
);

  logic                      cmd_dw_valid, cmd_dw_ready;
  logic [DataWidth-1:0]      cmd_dw;
  logic                      asm_valid, asm_ready;
  hci_cmd_t                  asm_cmd;
  logic                      tx_push, tx_wready;
  logic [DataWidth-1:0]      tx_wdata;
  logic                      rx_pop, rx_rvalid;
  logic [XferWidth-1:0]      rx_head;
  logic                      resp_pop, resp_rvalid;
  logic [RespWidth-1:0]      resp_head;
  hci_qrst_t                 qrst_req, qrst_clr, flush;
  logic [1:0][DataWidth-1:0] thld_raw;
  logic [DataWidth-1:0]      status;
  logic [CmdCntWidth-1:0]    cmd_cnt;
  logic [TxCntWidth-1:0]     tx_cnt;
  logic [RxCntWidth-1:0]     rx_cnt;
  logic [RespCntWidth-1:0]   resp_cnt;

  hci_csr_decode u_decode (
    .clk_i, .rst_ni, .apb_i, .apb_o,
    .cmd_dw_valid_o(cmd_dw_valid), .cmd_dw_o(cmd_dw), .cmd_dw_ready_i(cmd_dw_ready),
    .tx_push_o(tx_push), .tx_data_o(tx_wdata), .tx_full_i(!tx_wready),
    .rx_pop_o(rx_pop), .rx_head_i(rx_head), .rx_empty_i(!rx_rvalid),
    .resp_pop_o(resp_pop), .resp_head_i(resp_head), .resp_empty_i(!resp_rvalid),
    .qrst_req_o(qrst_req), .qrst_clr_i(qrst_clr),
    .thld_raw_o(thld_raw), .status_i(status)
  );

  hci_cmd_assembler u_assembler (
    .clk_i, .rst_ni,
    .dw_valid_i(cmd_dw_valid), .dw_i(cmd_dw), .dw_ready_o(cmd_dw_ready),
    .flush_i(flush.cmd),
    .cmd_valid_o(asm_valid), .cmd_o(asm_cmd), .cmd_ready_i(asm_ready)
  );

  // Clamped thresholds are consumed inside the controller for the status flags
  hci_queue_ctrl u_queue_ctrl (
    .clk_i, .rst_ni, .thld_raw_i(thld_raw), .qrst_req_i(qrst_req),
    .cmd_empty_i(!cmd_valid_o), .rx_empty_i(!rx_rvalid),
    .tx_empty_i(!tx_valid_o), .resp_empty_i(!resp_rvalid),
    .cmd_cnt_i(cmd_cnt), .rx_cnt_i(rx_cnt), .tx_cnt_i(tx_cnt), .resp_cnt_i(resp_cnt),
    .thld_o(), .flush_o(flush), .qrst_clr_o(qrst_clr), .status_o(status)
  );

  hci_fifo #(.Width(CmdWidth), .Depth(CmdDepth)) cmd_q (
    .clk_i, .rst_ni, .flush_i(flush.cmd),
    .wvalid_i(asm_valid), .wdata_i(asm_cmd), .wready_o(asm_ready),
    .rvalid_o(cmd_valid_o), .rdata_o(cmd_o), .rready_i(cmd_ready_i), .count_o(cmd_cnt)
  );

  hci_fifo #(.Width(XferWidth), .Depth(TxDepth)) tx_q (
    .clk_i, .rst_ni, .flush_i(flush.tx),
    .wvalid_i(tx_push), .wdata_i(tx_wdata), .wready_o(tx_wready),
    .rvalid_o(tx_valid_o), .rdata_o(tx_data_o), .rready_i(tx_ready_i), .count_o(tx_cnt)
  );

  hci_fifo #(.Width(XferWidth), .Depth(RxDepth)) rx_q (
    .clk_i, .rst_ni, .flush_i(flush.rx),
    .wvalid_i(rx_valid_i), .wdata_i(rx_data_i), .wready_o(rx_ready_o),
    .rvalid_o(rx_rvalid), .rdata_o(rx_head), .rready_i(rx_pop), .count_o(rx_cnt)
  );

  hci_fifo #(.Width(RespWidth), .Depth(RespDepth)) resp_q (
    .clk_i, .rst_ni, .flush_i(flush.resp),
    .wvalid_i(resp_valid_i), .wdata_i(resp_data_i), .wready_o(resp_ready_o),
    .rvalid_o(resp_rvalid), .rdata_o(resp_head), .rready_i(resp_pop), .count_o(resp_cnt)
  );

endmodule

`default_nettype wire

// File: verif/tb_hci_pio.sv
/* Testbench for the PIO queue block: APB tasks, controller model,
   status reference function, output checker and watchdog */
`timescale 1ns/1ps
`default_nettype none

module tb_hci_pio
  import hci_csr_pkg::*;
  import hci_queue_pkg::*;
();

  localparam int ClkPeriod = 20;
  localparam int NumTests  = 5;
  localparam int Seed      = 55455;

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  apb_req_t             apb_req;
  apb_rsp_t             apb_rsp;
  logic                 cmd_valid, cmd_ready;
  hci_cmd_t             cmd_out;
  logic                 tx_valid, tx_ready;
  logic [XferWidth-1:0] tx_data;
  logic                 rx_valid, rx_ready;
  logic [XferWidth-1:0] rx_data;
  logic                 resp_valid, resp_ready;
  logic [RespWidth-1:0] resp_data;

  logic        cmd_stall, tx_stall;  // Controller model holds ready low
  logic        rx_taken, resp_taken;
  logic [31:0] rx_send[$], resp_send[$];
  logic [63:0] cmd_exp[$];
  logic [31:0] tx_exp[$], rx_exp[$], resp_exp[$];
  int          value_errs, other_errs;

  hci_pio_top dut_i (
    .clk_i, .rst_ni, .apb_i(apb_req), .apb_o(apb_rsp),
    .cmd_valid_o(cmd_valid), .cmd_o(cmd_out), .cmd_ready_i(cmd_ready),
    .tx_valid_o(tx_valid), .tx_data_o(tx_data), .tx_ready_i(tx_ready),
    .rx_valid_i(rx_valid), .rx_data_i(rx_data), .rx_ready_o(rx_ready),
    .resp_valid_i(resp_valid), .resp_data_i(resp_data), .resp_ready_o(resp_ready)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    value_errs++;
    $display("Fail %s expected %0h actual %0h", name, exp, act);
  endtask

  task automatic report_error(input string what);
    other_errs++;
    $display("Error: %s", what);
  endtask

  // One APB transfer with its wait state count
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err, output int waits);
    waits = 0;
    @(posedge clk_i);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= wr;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge clk_i);
    apb_req.penable <= 1'b1;
    @(negedge clk_i);
    while (!apb_rsp.pready) begin
      waits++;
      @(negedge clk_i);
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk_i);  // Transfer ends on this edge
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data, output int waits);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, addr, data, rd, err, waits);
    if (err !== 1'b0) report_error($sformatf("write to offset %0h ended with pslverr", addr));
  endtask

  task automatic reg_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    int w;
    apb_xfer(1'b0, addr, '0, data, err, w);
  endtask

  task automatic write_cmd(input logic [31:0] lo, input logic [31:0] hi, output int waits);
    int w_lo, w_hi;
    cmd_exp.push_back({hi, lo});
    reg_write(COMMAND_PORT, lo, w_lo);
    reg_write(COMMAND_PORT, hi, w_hi);
    waits = w_lo + w_hi;
  endtask

  task automatic write_tx(input logic [31:0] data, output int waits);
    tx_exp.push_back(data);
    reg_write(XFER_DATA_PORT, data, waits);
  endtask

  task automatic send_words(input logic resp_side, input int n);
    logic [31:0] w;
    repeat (n) begin
      w = $urandom;
      if (resp_side) begin
        resp_send.push_back(w);
        resp_exp.push_back(w);
      end else begin
        rx_send.push_back(w);
        rx_exp.push_back(w);
      end
    end
  endtask

  // Reads a port until the words the model sent are used up
  task automatic read_all(input logic resp_port);
    logic [31:0] rd, exp;
    logic        err;
    while ((resp_port ? resp_exp.size() : rx_exp.size()) != 0) begin
      exp = resp_port ? resp_exp.pop_front() : rx_exp.pop_front();
      reg_read(resp_port ? RESPONSE_PORT : XFER_DATA_PORT, rd, err);
      if (err !== 1'b0) report_error("port read of a filled queue ended with pslverr");
      else if (rd !== exp) report_mismatch(resp_port ? "resp_read" : "rx_read", exp, rd);
    end
  endtask

  task automatic settle();
    while (rx_send.size() != 0 || rx_valid || resp_send.size() != 0 || resp_valid)
      @(negedge clk_i);
    repeat (2) @(posedge clk_i);
  endtask

  task automatic wait_drain();
    while (cmd_exp.size() != 0 || tx_exp.size() != 0) @(posedge clk_i);
  endtask

  // QUEUE_STATUS from raw threshold registers and queue fill levels
  function automatic logic [31:0] exp_status(input logic [31:0] q_thld, input logic [31:0] d_thld,
                                             input int n_cmd, input int n_rx,
                                             input int n_tx, input int n_resp);
    int          cmd_t, resp_t, tx_f, rx_f;
    logic [31:0] s;
    cmd_t  = q_thld[7:0];
    resp_t = q_thld[15:8];
    tx_f   = d_thld[2:0];
    rx_f   = d_thld[10:8];
    if (cmd_t > CmdDepth) cmd_t = CmdDepth;
    if (resp_t > RespDepth - 1) resp_t = RespDepth - 1;
    if ((1 << (tx_f + 1)) > TxDepth) tx_f = 3;
    if ((1 << (rx_f + 1)) >= RxDepth) rx_f = 2;
    s       = '0;
    s[0]    = n_cmd == 0;
    s[1]    = n_rx == 0;
    s[2]    = n_tx == 0;
    s[3]    = n_resp == 0;
    s[4]    = (CmdDepth - n_cmd) >= cmd_t;
    s[5]    = n_resp > resp_t;
    s[6]    = (TxDepth - n_tx) >= (1 << (tx_f + 1));
    s[7]    = n_rx >= (1 << (rx_f + 1));
    s[15:8] = cmd_t[7:0];
    return s;
  endfunction

  // Controller model, drives ready and the RX and response streams
  always @(posedge clk_i) begin
    cmd_ready <= !cmd_stall;
    tx_ready  <= !tx_stall;
    if (rx_taken || !rx_valid) begin
      if (rx_send.size() != 0) begin
        rx_valid <= 1'b1;
        rx_data  <= rx_send.pop_front();
      end else begin
        rx_valid <= 1'b0;
      end
    end
    if (resp_taken || !resp_valid) begin
      if (resp_send.size() != 0) begin
        resp_valid <= 1'b1;
        resp_data  <= resp_send.pop_front();
      end else begin
        resp_valid <= 1'b0;
      end
    end
  end

  // Compare process, handshakes are seen mid cycle
  always @(negedge clk_i) begin : check_outputs
    logic [63:0] exp_cmd;
    logic [31:0] exp_tx;
    rx_taken   = rx_valid && rx_ready;
    resp_taken = resp_valid && resp_ready;
    if (cmd_valid && cmd_ready) begin
      if (cmd_exp.size() == 0) begin
        report_error($sformatf("unexpected command %0h at cmd_o", cmd_out));
      end else begin
        exp_cmd = cmd_exp.pop_front();
        if (cmd_out !== exp_cmd) report_mismatch("cmd_order", exp_cmd, cmd_out);
      end
    end
    if (tx_valid && tx_ready) begin
      if (tx_exp.size() == 0) begin
        report_error($sformatf("unexpected TX word %0h at tx_data_o", tx_data));
      end else begin
        exp_tx = tx_exp.pop_front();
        if (tx_data !== exp_tx) report_mismatch("tx_order", exp_tx, tx_data);
      end
    end
  end

  task automatic test_commands();
    int w, total;
    repeat (20) write_cmd($urandom, $urandom, w);
    wait_drain();
    cmd_stall <= 1'b1;  // Eight fill the queue, the ninth parks in the assembler
    total     = 0;
    repeat (9) begin
      write_cmd($urandom, $urandom, w);
      total += w;
    end
    if (total != 0) report_error("command writes waited while the command queue had room");
    fork
      write_cmd($urandom, $urandom, w);
      begin
        repeat (12) @(posedge clk_i);
        cmd_stall <= 1'b0;
      end
    join
    if (w < 5) report_error("command write did not wait while the command queue was full");
    wait_drain();
  endtask

  task automatic test_tx();
    int w, total;
    tx_stall <= 1'b1;
    total    = 0;
    repeat (TxDepth) begin
      write_tx($urandom, w);
      total += w;
    end
    if (total != 0) report_error("TX writes waited while the TX queue had room");
    fork
      write_tx($urandom, w);
      begin
        repeat (12) @(posedge clk_i);
        tx_stall <= 1'b0;
      end
    join
    if (w < 5) report_error("TX write did not wait while the TX queue was full");
    repeat (20) write_tx($urandom, w);
    wait_drain();
  endtask

  task automatic test_rx_resp();
    logic [31:0] rd;
    logic        err;
    int          w;
    send_words(1'b0, 10);
    send_words(1'b1, 5);
    settle();
    read_all(1'b0);
    read_all(1'b1);
    reg_read(XFER_DATA_PORT, rd, err);
    if (err !== 1'b1) report_mismatch("rx_empty_err", 1, err);
    reg_read(RESPONSE_PORT, rd, err);
    if (err !== 1'b1) report_mismatch("resp_empty_err", 1, err);
    reg_read(8'h1C, rd, err);
    if (err !== 1'b1) report_mismatch("unmapped_read_err", 1, err);
    apb_xfer(1'b1, 8'h40, $urandom, rd, err, w);
    if (err !== 1'b1) report_mismatch("unmapped_write_err", 1, err);
  endtask

  task automatic test_thresholds();
    logic [31:0] q_thld, d_thld, rd, exp;
    logic        err;
    int          n_cmd, n_tx, n_rx, n_resp, w;
    repeat (6) begin
      n_cmd  = $urandom_range(CmdDepth);
      n_tx   = $urandom_range(TxDepth);
      n_rx   = $urandom_range(RxDepth);
      n_resp = $urandom_range(RespDepth);
      q_thld = ($urandom & 32'hFFFF_0000) | ($urandom_range(10) << 8) | $urandom_range(12);
      d_thld = ($urandom & 32'hFFFF_F8F8) | ($urandom_range(7) << 8) | $urandom_range(7);
      cmd_stall <= 1'b1;
      tx_stall  <= 1'b1;
      repeat (n_cmd) write_cmd($urandom, $urandom, w);
      repeat (n_tx) write_tx($urandom, w);
      send_words(1'b0, n_rx);
      send_words(1'b1, n_resp);
      settle();
      reg_write(QUEUE_THLD_CTRL, q_thld, w);
      reg_write(DATA_BUFFER_THLD_CTRL, d_thld, w);
      exp = exp_status(q_thld, d_thld, n_cmd, n_rx, n_tx, n_resp);
      reg_read(QUEUE_STATUS, rd, err);
      if (rd !== exp) report_mismatch("queue_status", exp, rd);
      read_all(1'b0);
      read_all(1'b1);
      cmd_stall <= 1'b0;
      tx_stall  <= 1'b0;
      wait_drain();
    end
  endtask

  task automatic test_queue_reset();
    logic [31:0] rd;
    logic        err;
    int          w;
    tx_stall <= 1'b1;
    repeat (TxDepth) write_tx($urandom, w);
    send_words(1'b1, RespDepth);
    settle();
    reg_write(RESET_CONTROL, (32'd1 << RstTxBit) | (32'd1 << RstRespBit), w);
    tx_exp.delete();    // Flushed words never reach the controller
    resp_exp.delete();
    repeat (5) @(posedge clk_i);
    reg_read(RESET_CONTROL, rd, err);
    if (rd !== 32'h0) report_mismatch("reset_self_clear", 0, rd);
    reg_read(QUEUE_STATUS, rd, err);
    if (rd[3:0] !== 4'hF) report_mismatch("reset_empty_flags", 4'hF, rd[3:0]);
    tx_stall <= 1'b0;
    repeat (3) write_tx($urandom, w);
    send_words(1'b1, 2);
    settle();
    read_all(1'b1);
    wait_drain();
  endtask

  initial begin : watchdog
    #(NumTests * 2000 * ClkPeriod);
    $display("Error: watchdog timeout, the tests did not finish in time");
    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs + 1);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(Seed));
    apb_req    = '0;
    cmd_ready  = 1'b0;
    tx_ready   = 1'b0;
    rx_valid   = 1'b0;
    rx_data    = '0;
    resp_valid = 1'b0;
    resp_data  = '0;
    cmd_stall  = 1'b0;
    tx_stall   = 1'b0;
    rx_taken   = 1'b0;
    resp_taken = 1'b0;
    value_errs = 0;
    other_errs = 0;
    rst_ni     = 1'b0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (3) @(posedge clk_i);
    test_commands();
    test_tx();
    test_rx_resp();
    test_thresholds();
    test_queue_reset();
    wait_drain();
    if (rx_exp.size() != 0 || resp_exp.size() != 0) report_error("words left unread in a queue");
    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
common/hci_csr_pkg.sv
common/hci_queue_pkg.sv
queues/hci_fifo.sv
source/hci_csr_decode.sv
source/hci_cmd_assembler.sv
source/hci_queue_ctrl.sv
source/hci_pio_top.sv
verif/tb_hci_pio.sv
